// File: design/tex_cfg.svh
`ifndef TEX_CFG_SVH
`define TEX_CFG_SVH

// ==============================
// Texture cache sizing
// ==============================

// SRAM word address width
`define TEX_ADDR_W 24

// Burst word and texel widths
`define WORD_W 16
`define TEXEL_W 18

// Pixel coordinate width
`define COORD_W 10

// Set index width for 64 lines
`define SET_BITS 6

// Words per 4x4 block
`define BURST_LEN_RGBA4444 16
`define BURST_LEN_BC1 4

`endif

// File: design/tex_pkg.sv
`include "tex_cfg.svh"

package tex_pkg;

    // Texels per 4x4 block
    localparam int BLOCK_TEXELS = 16;

    // Lowest base address bit kept in the tag
    localparam int TAG_BASE_LSB = 12;

    // Texture formats
    typedef enum logic [1:0] {
        FMT_RGBA4444 = 2'd0,
        FMT_BC1      = 2'd1
    } tex_format_t;

    // R5 G6 B5 A2
    typedef logic [`TEXEL_W-1:0] texel_t;

    // Base address high bits, block_y low bits, block_x low bits
    typedef logic [`TEX_ADDR_W-TAG_BASE_LSB+2*`SET_BITS-1:0] tag_t;

    typedef logic [`SET_BITS-1:0] set_idx_t;
    typedef logic [`TEX_ADDR_W-1:0] sram_addr_t;

    // Raw burst words and decoded block, raster order
    typedef logic [`BURST_LEN_RGBA4444-1:0][`WORD_W-1:0] burst_buf_t;
    typedef logic [BLOCK_TEXELS-1:0][`TEXEL_W-1:0] texel_block_t;

endpackage

// File: design/block_locator.sv
`timescale 1ns/1ps
`include "tex_cfg.svh"

module block_locator
    import tex_pkg::*;
(
    input  logic [`COORD_W-1:0] pixel_x,
    input  logic [`COORD_W-1:0] pixel_y,
    input  sram_addr_t          tex_base_addr,
    input  tex_format_t         tex_format,
    input  logic [7:0]          tex_width_log2,
    output set_idx_t            set_index,
    output tag_t                lookup_tag,
    output sram_addr_t          block_addr,
    output logic [7:0]          burst_len,
    output logic [1:0]          quad_sel
);

    localparam int BLK_W = `COORD_W - 2;

    logic [BLK_W-1:0]   block_x;
    logic [BLK_W-1:0]   block_y;
    logic [7:0]         row_shift;
    logic [2*BLK_W-1:0] block_index;

    // Pixel to 4x4 block coordinates
    assign block_x = pixel_x[`COORD_W-1:2];
    assign block_y = pixel_y[`COORD_W-1:2];

    // XOR fold spreads neighbouring blocks over sets
    assign set_index = block_x[`SET_BITS-1:0] ^ block_y[`SET_BITS-1:0];
    assign lookup_tag = {tex_base_addr[`TEX_ADDR_W-1:TAG_BASE_LSB],
                         block_y[`SET_BITS-1:0], block_x[`SET_BITS-1:0]};

    // Blocks per row is width / 4
    assign row_shift   = tex_width_log2 - 8'd2;
    assign block_index = ({{BLK_W{1'b0}}, block_y} << row_shift) + {{BLK_W{1'b0}}, block_x};

    // Block size in words sets both the stride and the burst
    always_comb begin
        if (tex_format == FMT_RGBA4444) begin
            block_addr = tex_base_addr + sram_addr_t'({block_index, 4'b0000});
            burst_len  = 8'(`BURST_LEN_RGBA4444);
        end else begin
            block_addr = tex_base_addr + sram_addr_t'({block_index, 2'b00});
            burst_len  = 8'(`BURST_LEN_BC1);
        end
    end

    // Quad within the block
    assign quad_sel = {pixel_y[1], pixel_x[1]};

endmodule

// File: design/tag_array.sv
`timescale 1ns/1ps
`include "tex_cfg.svh"

module tag_array
    import tex_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  set_idx_t set_index,
    input  tag_t     lookup_tag,
    input  logic     invalidate,
    input  logic     write_done,
    input  set_idx_t fill_set,
    input  tag_t     fill_tag,
    output logic     match
);

    localparam int NUM_LINES = 1 << `SET_BITS;

    // ==============================
    // Line state
    // ==============================

    tag_t                 tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] line_valid;

    // Tag written on the last bank write of a fill
    always_ff @(posedge clk) begin
        if (write_done) begin
            tag_mem[fill_set] <= fill_tag;
        end
    end

    // Invalidate beats a fill landing in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else if (invalidate) begin
            line_valid <= '0;
        end else if (write_done) begin
            line_valid[fill_set] <= 1'b1;
        end
    end

    // ==============================
    // Lookup compare
    // ==============================

    // Direct mapped, single compare per lookup
    assign match = line_valid[set_index] && (tag_mem[set_index] == lookup_tag);

endmodule

// File: design/fill_controller.sv
`timescale 1ns/1ps
`include "tex_cfg.svh"

module fill_controller
    import tex_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                lookup_req,
    input  logic                match,
    input  set_idx_t            set_index,
    input  tag_t                lookup_tag,
    input  sram_addr_t          block_addr,
    input  logic [7:0]          burst_len,
    input  tex_format_t         tex_format,
    input  logic [`WORD_W-1:0]  sram_burst_rdata,
    input  logic                sram_burst_data_valid,
    input  logic                sram_ack,
    input  logic                write_done,
    output logic                cache_hit,
    output logic                cache_ready,
    output logic                sram_req,
    output sram_addr_t          sram_addr,
    output logic [7:0]          sram_burst_len,
    output set_idx_t            fill_set,
    output tag_t                fill_tag,
    output tex_format_t         fill_format,
    output burst_buf_t          burst_buf,
    output logic                decode_start
);

    typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_DECODE, ST_WRITE} fill_state_t;

    fill_state_t state;
    logic [4:0]  word_cnt;
    logic        miss;
    logic        capture;

    // Lookups only count while idle
    assign miss         = lookup_req && !match && (state == ST_IDLE);
    assign cache_hit    = lookup_req && match && (state == ST_IDLE);
    assign cache_ready  = (state == ST_IDLE);
    assign decode_start = (state == ST_DECODE);
    assign capture      = (state == ST_FETCH) && sram_burst_data_valid && (word_cnt < 5'd16);

    // ==============================
    // Fill FSM
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:   if (miss) state <= ST_FETCH;
                ST_FETCH:  if (sram_ack) state <= ST_DECODE;
                ST_DECODE: state <= ST_WRITE;
                ST_WRITE:  if (write_done) state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Request held from the miss until ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sram_req       <= 1'b0;
            sram_addr      <= '0;
            sram_burst_len <= '0;
        end else if (miss) begin
            sram_req       <= 1'b1;
            sram_addr      <= block_addr;
            sram_burst_len <= burst_len;
        end else if ((state == ST_FETCH) && sram_ack) begin
            sram_req       <= 1'b0;
            sram_burst_len <= '0;
        end
    end

    // Word count restarts on every miss
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (miss) begin
            word_cnt <= '0;
        end else if (capture) begin
            word_cnt <= word_cnt + 5'd1;
        end
    end

    // Fill line identity and raw words
    always_ff @(posedge clk) begin
        if (miss) begin
            fill_set    <= set_index;
            fill_tag    <= lookup_tag;
            fill_format <= tex_format;
        end
        if (capture) begin
            burst_buf[word_cnt[3:0]] <= sram_burst_rdata;
        end
    end

    // Arbiter never cuts a burst short, last word may ride with ack
    ack_after_all_words: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == ST_FETCH) && sram_ack) |->
            (({3'b000, word_cnt} + 8'(sram_burst_data_valid)) >= sram_burst_len));

    req_only_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        sram_req |-> (state == ST_FETCH));

endmodule

// File: design/texel_decoder.sv
`timescale 1ns/1ps
`include "tex_cfg.svh"

module texel_decoder
    import tex_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         decode_start,
    input  tex_format_t  fill_format,
    input  burst_buf_t   burst_buf,
    output logic         block_valid,
    output texel_block_t texels
);

    // RGBA4444 widened by top bit replication, alpha keeps two bits
    function automatic texel_t widen_4444(input logic [`WORD_W-1:0] w);
        return {w[15:12], w[15], w[11:8], w[11:10], w[7:4], w[7], w[3:2]};
    endfunction

    // One channel blend, two thirds a plus one third b, or the mean
    function automatic logic [5:0] blend_ch(input logic [5:0] a, input logic [5:0] b,
                                            input logic half);
        logic [7:0] sum3;
        logic [6:0] sum2;
        sum3 = {2'b00, a} + {2'b00, a} + {2'b00, b} + 8'd1;
        sum2 = {1'b0, a} + {1'b0, b};
        if (half) begin
            return sum2[6:1];
        end
        return 6'(sum3 / 8'd3);
    endfunction

    // RGB565 blend, 5 bit channels padded to 6
    function automatic logic [15:0] blend_565(input logic [15:0] a, input logic [15:0] b,
                                              input logic half);
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] bl;
        r  = blend_ch({1'b0, a[15:11]}, {1'b0, b[15:11]}, half);
        g  = blend_ch(a[10:5], b[10:5], half);
        bl = blend_ch({1'b0, a[4:0]}, {1'b0, b[4:0]}, half);
        return {r[4:0], g, bl[4:0]};
    endfunction

    logic [`WORD_W-1:0] color0;
    logic [`WORD_W-1:0] color1;
    logic [31:0]        index_bits;
    logic               four_color;
    logic [`WORD_W-1:0] palette [4];
    texel_block_t       decoded;

    // ==============================
    // BC1 palette
    // ==============================

    assign color0     = burst_buf[0];
    assign color1     = burst_buf[1];
    assign index_bits = {burst_buf[3], burst_buf[2]};
    assign four_color = color0 > color1;

    always_comb begin
        palette[0] = color0;
        palette[1] = color1;
        if (four_color) begin
            palette[2] = blend_565(color0, color1, 1'b0);
            palette[3] = blend_565(color1, color0, 1'b0);
        end else begin
            palette[2] = blend_565(color0, color1, 1'b1);
            palette[3] = '0;
        end
    end

    // Per texel decode
    always_comb begin
        for (int t = 0; t < BLOCK_TEXELS; t++) begin
            if (fill_format == FMT_RGBA4444) begin
                decoded[t] = widen_4444(burst_buf[t]);
            end else if (!four_color && (index_bits[2*t +: 2] == 2'b11)) begin
                // Transparent black
                decoded[t] = '0;
            end else begin
                decoded[t] = {palette[index_bits[2*t +: 2]], 2'b11};
            end
        end
    end

    // Output block held until the next decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_valid <= 1'b0;
        end else begin
            block_valid <= decode_start;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_start) begin
            texels <= decoded;
        end
    end

endmodule

// File: design/texel_banks.sv
`timescale 1ns/1ps
`include "tex_cfg.svh"

module texel_banks
    import tex_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         block_valid,
    input  texel_block_t texels,
    input  set_idx_t     fill_set,
    input  set_idx_t     set_index,
    input  logic [1:0]   quad_sel,
    output texel_t       texel_out_0,
    output texel_t       texel_out_1,
    output texel_t       texel_out_2,
    output texel_t       texel_out_3,
    output logic         write_done
);

    localparam int LINE_AW = `SET_BITS + 2;

    logic               wr_busy;
    logic [1:0]         wr_cnt;
    logic [1:0]         wr_sub;
    logic               wr_en;
    logic [LINE_AW-1:0] wr_addr;
    logic [LINE_AW-1:0] rd_addr;
    texel_t             rd_texel [4];

    // Sub-address 0 goes with block_valid, 1 to 3 follow
    assign wr_en      = block_valid || wr_busy;
    assign wr_sub     = wr_busy ? wr_cnt : 2'd0;
    assign wr_addr    = {fill_set, wr_sub};
    assign rd_addr    = {set_index, quad_sel};
    assign write_done = wr_busy && (wr_cnt == 2'd3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_busy <= 1'b0;
            wr_cnt  <= 2'd0;
        end else if (block_valid) begin
            wr_busy <= 1'b1;
            wr_cnt  <= 2'd1;
        end else if (wr_busy) begin
            wr_cnt <= wr_cnt + 2'd1;
            if (wr_cnt == 2'd3) wr_busy <= 1'b0;
        end
    end

    // Bank {ty[0], tx[0]}, sub-address {ty[1], tx[1]}
    for (genvar b = 0; b < 4; b++) begin : g_bank
        localparam logic [1:0] BANK = 2'(b);
        texel_t mem [1 << LINE_AW];
        always_ff @(posedge clk) begin
            if (wr_en) mem[wr_addr] <= texels[{wr_sub[1], BANK[1], wr_sub[0], BANK[0]}];
        end
        assign rd_texel[b] = mem[rd_addr];
    end

    assign texel_out_0 = rd_texel[0];
    assign texel_out_1 = rd_texel[1];
    assign texel_out_2 = rd_texel[2];
    assign texel_out_3 = rd_texel[3];

    // Decoder must not hand over a new block mid write
    no_overlapping_write: assert property (@(posedge clk) disable iff (!rst_n)
        block_valid |-> !wr_busy);

endmodule

// File: design/texture_cache.sv
`timescale 1ns/1ps
`include "tex_cfg.svh"

module texture_cache
    import tex_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               lookup_req,
    input  logic [`COORD_W-1:0] pixel_x,
    input  logic [`COORD_W-1:0] pixel_y,
    input  sram_addr_t         tex_base_addr,
    input  tex_format_t        tex_format,
    input  logic [7:0]         tex_width_log2,
    input  logic               invalidate,
    input  logic [`WORD_W-1:0] sram_burst_rdata,
    input  logic               sram_burst_data_valid,
    input  logic               sram_ack,
    output logic               cache_hit,
    output logic               cache_ready,
    output logic               fill_done,
    output texel_t             texel_out_0,
    output texel_t             texel_out_1,
    output texel_t             texel_out_2,
    output texel_t             texel_out_3,
    output logic               sram_req,
    output sram_addr_t         sram_addr,
    output logic [7:0]         sram_burst_len
);

    // ==============================
    // Stage wiring
    // ==============================

    set_idx_t     set_index;
    tag_t         lookup_tag;
    sram_addr_t   block_addr;
    logic [7:0]   burst_len;
    logic [1:0]   quad_sel;
    logic         match;
    set_idx_t     fill_set;
    tag_t         fill_tag;
    tex_format_t  fill_format;
    burst_buf_t   burst_buf;
    logic         decode_start;
    logic         block_valid;
    texel_block_t texels;
    logic         write_done;

    assign fill_done = write_done;

    block_locator block_locator_inst (
        .pixel_x(pixel_x), .pixel_y(pixel_y), .tex_base_addr(tex_base_addr),
        .tex_format(tex_format), .tex_width_log2(tex_width_log2),
        .set_index(set_index), .lookup_tag(lookup_tag), .block_addr(block_addr),
        .burst_len(burst_len), .quad_sel(quad_sel)
    );

    tag_array tag_array_inst (
        .clk(clk), .rst_n(rst_n), .set_index(set_index), .lookup_tag(lookup_tag),
        .invalidate(invalidate), .write_done(write_done), .fill_set(fill_set),
        .fill_tag(fill_tag), .match(match)
    );

    fill_controller fill_controller_inst (
        .clk(clk), .rst_n(rst_n), .lookup_req(lookup_req), .match(match),
        .set_index(set_index), .lookup_tag(lookup_tag), .block_addr(block_addr),
        .burst_len(burst_len), .tex_format(tex_format),
        .sram_burst_rdata(sram_burst_rdata), .sram_burst_data_valid(sram_burst_data_valid),
        .sram_ack(sram_ack), .write_done(write_done), .cache_hit(cache_hit),
        .cache_ready(cache_ready), .sram_req(sram_req), .sram_addr(sram_addr),
        .sram_burst_len(sram_burst_len), .fill_set(fill_set), .fill_tag(fill_tag),
        .fill_format(fill_format), .burst_buf(burst_buf), .decode_start(decode_start)
    );

    texel_decoder texel_decoder_inst (
        .clk(clk), .rst_n(rst_n), .decode_start(decode_start), .fill_format(fill_format),
        .burst_buf(burst_buf), .block_valid(block_valid), .texels(texels)
    );

    texel_banks texel_banks_inst (
        .clk(clk), .rst_n(rst_n), .block_valid(block_valid), .texels(texels),
        .fill_set(fill_set), .set_index(set_index), .quad_sel(quad_sel),
        .texel_out_0(texel_out_0), .texel_out_1(texel_out_1),
        .texel_out_2(texel_out_2), .texel_out_3(texel_out_3), .write_done(write_done)
    );

endmodule

// File: tb/tb_texture_cache.sv
`timescale 1ns/1ps
`include "tex_cfg.svh"

module tb_texture_cache
    import tex_pkg::*;
();

    // Record layout as in the data file header
    localparam int REC_WORDS = 29;
    localparam int MAX_RECS  = 32;
    localparam int TIMEOUT   = 64;

    logic               clk;
    logic               rst_n;
    logic               lookup_req;
    logic [`COORD_W-1:0] pixel_x;
    logic [`COORD_W-1:0] pixel_y;
    sram_addr_t         tex_base_addr;
    tex_format_t        tex_format;
    logic [7:0]         tex_width_log2;
    logic               invalidate;
    logic [`WORD_W-1:0] sram_burst_rdata;
    logic               sram_burst_data_valid;
    logic               sram_ack;
    logic               cache_hit;
    logic               cache_ready;
    logic               fill_done;
    texel_t             texel_out_0;
    texel_t             texel_out_1;
    texel_t             texel_out_2;
    texel_t             texel_out_3;
    logic               sram_req;
    sram_addr_t         sram_addr;
    logic [7:0]         sram_burst_len;

    logic [31:0] tdata [REC_WORDS*MAX_RECS];
    logic [31:0] rng;
    int          err_count;
    int          timeout_count;
    int          bad_count;

    // Last completed lookup replayed while the cache is busy
    logic [31:0] prev_px;
    logic [31:0] prev_py;
    logic [31:0] prev_base;
    logic [31:0] prev_fmt;
    logic [31:0] prev_wlog2;

    texture_cache texture_cache_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic drive_lookup(input logic [31:0] px, input logic [31:0] py,
                                input logic [31:0] base, input logic [31:0] fmt,
                                input logic [31:0] wlog2);
        pixel_x        = px[`COORD_W-1:0];
        pixel_y        = py[`COORD_W-1:0];
        tex_base_addr  = base[`TEX_ADDR_W-1:0];
        tex_format     = tex_format_t'(fmt[1:0]);
        tex_width_log2 = wlog2[7:0];
    endtask

    // Quad readout against the record's expected texels
    task automatic compare_texels(input int b);
        compare_value("texel_out_0", 32'(texel_out_0), tdata[b+9]);
        compare_value("texel_out_1", 32'(texel_out_1), tdata[b+10]);
        compare_value("texel_out_2", 32'(texel_out_2), tdata[b+11]);
        compare_value("texel_out_3", 32'(texel_out_3), tdata[b+12]);
    endtask

    // SRAM side of one burst with ack on the last word
    task automatic stream_burst(input int b);
        int len;
        len = (tdata[b+8] > 16) ? 16 : int'(tdata[b+8]);
        for (int w = 0; w < len; w++) begin
            rng = lcg_next(rng);
            // Idle beats between words
            repeat (rng[31:30]) begin
                @(negedge clk);
                sram_burst_data_valid = 1'b0;
                sram_ack              = 1'b0;
            end
            @(negedge clk);
            sram_burst_rdata      = tdata[b+13+w][`WORD_W-1:0];
            sram_burst_data_valid = 1'b1;
            sram_ack              = (w == len - 1);
        end
        @(negedge clk);
        sram_burst_data_valid = 1'b0;
        sram_ack              = 1'b0;
    endtask

    task automatic apply_invalidate();
        @(negedge clk);
        invalidate = 1'b1;
        @(negedge clk);
        invalidate = 1'b0;
    endtask

    // ==============================
    // One lookup record
    // ==============================

    task automatic run_lookup(input int b);
        int   cnt;
        logic hit;
        hit = tdata[b+6][0];
        @(negedge clk);
        drive_lookup(tdata[b+1], tdata[b+2], tdata[b+3], tdata[b+4], tdata[b+5]);
        lookup_req = 1'b1;
        #1;
        compare_value("cache_ready", 32'(cache_ready), 32'd1);
        compare_value("cache_hit", 32'(cache_hit), 32'(hit));
        if (hit) begin
            compare_texels(b);
            @(negedge clk);
            lookup_req = 1'b0;
            #1;
            compare_value("sram_req", 32'(sram_req), 32'd0);
        end else begin
            @(negedge clk);
            lookup_req = 1'b0;
            #1;
            cnt = 0;
            while (!sram_req && cnt < TIMEOUT) begin
                @(negedge clk);
                #1;
                cnt++;
            end
            if (!sram_req) begin
                $display("timed out waiting for sram_req after a miss at %0t ns", $time);
                timeout_count++;
                return;
            end
            compare_value("sram_addr", 32'(sram_addr), tdata[b+7]);
            compare_value("sram_burst_len", 32'(sram_burst_len), tdata[b+8]);
            // Lookup while busy must be ignored
            @(negedge clk);
            drive_lookup(prev_px, prev_py, prev_base, prev_fmt, prev_wlog2);
            lookup_req = 1'b1;
            #1;
            compare_value("cache_hit", 32'(cache_hit), 32'd0);
            compare_value("cache_ready", 32'(cache_ready), 32'd0);
            @(negedge clk);
            lookup_req = 1'b0;
            drive_lookup(tdata[b+1], tdata[b+2], tdata[b+3], tdata[b+4], tdata[b+5]);
            #1;
            // Request still points at the block being fetched
            compare_value("sram_addr", 32'(sram_addr), tdata[b+7]);
            stream_burst(b);
            #1;
            // No second request until the line is written
            cnt = 0;
            while (!fill_done && cnt < TIMEOUT) begin
                compare_value("sram_req", 32'(sram_req), 32'd0);
                @(negedge clk);
                #1;
                cnt++;
            end
            if (!fill_done) begin
                $display("timed out waiting for fill_done at %0t ns", $time);
                timeout_count++;
                return;
            end
            @(negedge clk);
            #1;
            compare_value("cache_ready", 32'(cache_ready), 32'd1);
            compare_texels(b);
        end
        prev_px    = tdata[b+1];
        prev_py    = tdata[b+2];
        prev_base  = tdata[b+3];
        prev_fmt   = tdata[b+4];
        prev_wlog2 = tdata[b+5];
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int b;
        bit done;
        rst_n                 = 1'b0;
        lookup_req            = 1'b0;
        invalidate            = 1'b0;
        sram_burst_rdata      = '0;
        sram_burst_data_valid = 1'b0;
        sram_ack              = 1'b0;
        drive_lookup(32'd0, 32'd0, 32'd0, 32'd0, 32'd6);
        prev_px       = '0;
        prev_py       = '0;
        prev_base     = '0;
        prev_fmt      = '0;
        prev_wlog2    = 32'd6;
        rng           = 32'h3744_07ed;
        err_count     = 0;
        timeout_count = 0;
        bad_count     = 0;
        done          = 1'b0;
        $readmemh("tb/texture_testdata.txt", tdata);

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        compare_value("sram_req", 32'(sram_req), 32'd0);
        compare_value("fill_done", 32'(fill_done), 32'd0);
        compare_value("cache_hit", 32'(cache_hit), 32'd0);
        compare_value("cache_ready", 32'(cache_ready), 32'd1);

        for (int r = 0; r < MAX_RECS && !done; r++) begin
            b = r * REC_WORDS;
            case (tdata[b])
                32'd0: run_lookup(b);
                32'd1: apply_invalidate();
                32'd2: done = 1'b1;
                default: begin
                    $display("record %0d has an unknown operation code", r);
                    bad_count++;
                    done = 1'b1;
                end
            endcase
        end
        if (!done) begin
            $display("test data ends without an end record");
            bad_count++;
        end

        $display("checks done: %0d mismatches, %0d timeouts, %0d bad records",
                 err_count, timeout_count, bad_count);
        if (err_count == 0 && timeout_count == 0 && bad_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb/texture_testdata.txt
// Line 1: op(0 lookup 1 invalidate 2 end) px py base fmt wlog2 hit addr len tex0 tex1 tex2 tex3
// Line 2: sixteen burst words, word 0 first
0 005 009 010000 0 6 0 010210 10 01fb3 05dbb 11712 1551a
0f6c 1e7d 2d4e 3c5f 4b28 5a39 690a 781b 87e4 96f5 a5c6 b4d7 c3a0 d2b1 e182 f093
0 007 009 010000 0 6 1 0 0 09ba3 0d9ab 19302 1d10a
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0 005 00b 010000 0 6 1 0 0 22ef5 26cfd 32654 3645c
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0 007 00b 010000 0 6 1 0 0 2aae5 2e8ed 3a244 3e04c
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0 010 000 020000 1 6 0 020010 4 3ff83 0007f 2b52b 14ad7
ffe0 001f 0e04 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0 002 016 030000 1 5 0 0300a0 4 01fff 3e003 1efbf 00000
07ff f800 5555 e040 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0 008 004 010000 0 6 0 010120 10 22890 22890 22890 22890
8421 8421 8421 8421 8421 8421 8421 8421 8421 8421 8421 8421 8421 8421 8421 8421
0 005 009 010000 0 6 0 010210 10 01fb3 05dbb 11712 1551a
0f6c 1e7d 2d4e 3c5f 4b28 5a39 690a 781b 87e4 96f5 a5c6 b4d7 c3a0 d2b1 e182 f093
0 010 000 020000 1 6 1 0 0 3ff83 0007f 2b52b 14ad7
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 0 0 0 0 0 0 0 0 0
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0 010 000 020000 1 6 0 020010 4 3ff83 0007f 2b52b 14ad7
ffe0 001f 0e04 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
2 0 0 0 0 0 0 0 0 0 0 0 0
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

// File: sim.f
+incdir+design
design/tex_pkg.sv
design/block_locator.sv
design/tag_array.sv
design/fill_controller.sv
design/texel_decoder.sv
design/texel_banks.sv
design/texture_cache.sv
tb/tb_texture_cache.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tb_texture_cache
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation PASSED

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
